// File: verilog/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic {
		MUL_IDLE,
		MUL_BUSY
	} mul_state_e;

	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     imm;
		logic      use_imm;
		logic      use_zero_rs1;
		alu_op_e   alu_op;
		logic      is_mul;
	} decoded_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t     result;
	} retire_t;

	// major opcodes
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	localparam int INST_QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W      = 2;
	localparam int MUL_STEPS        = 32;

endpackage

// File: verilog/inst_queue.sv
`timescale 1ns/1ps

module inst_queue
	import core_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  push_i,
	input  inst_t push_inst_i,
	output logic  head_valid_o,
	output inst_t head_inst_o,
	input  logic  pop_i,
	output logic  credit_o
);

	inst_t                  mem_q [INST_QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr_q;
	logic [QUEUE_PTR_W-1:0] rd_ptr_q;
	logic [QUEUE_PTR_W:0]   count_q;
	logic                   pop;
	logic                   full;

	assign head_valid_o = (count_q != '0);
	assign head_inst_o  = mem_q[rd_ptr_q];
	assign full         = (count_q == (QUEUE_PTR_W + 1)'(INST_QUEUE_DEPTH));
	assign pop          = pop_i & head_valid_o;

	always_ff @(posedge clock) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= push_inst_i;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_o <= 1'b0;
		end else begin
			// one credit back per entry handed to issue
			credit_o <= pop;
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push_i, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// sender must hold a credit for every push
	no_overflow_a: assert property (@(posedge clock) disable iff (reset) push_i |-> !full)
		else $error("inst_queue: push while full");

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ps

module decoder
	import core_pkg::*;
(
	input  inst_t    inst_i,
	output decoded_t dec_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		// default is a no-op: rd 0, result 0 + 0
		dec_o              = '0;
		dec_o.rs1          = inst_i[19:15];
		dec_o.rs2          = inst_i[24:20];
		dec_o.use_imm      = 1'b1;
		dec_o.use_zero_rs1 = 1'b1;
		dec_o.alu_op       = ALU_ADD;
		case (opcode)
			OPC_LUI: begin
				dec_o.rd  = inst_i[11:7];
				dec_o.imm = {inst_i[31:12], 12'b0};
			end
			OPC_OP_IMM: begin
				dec_o.rd           = inst_i[11:7];
				dec_o.use_zero_rs1 = 1'b0;
				dec_o.imm          = {{20{inst_i[31]}}, inst_i[31:20]};
				case (funct3)
					3'b000: dec_o.alu_op = ALU_ADD;
					3'b010: dec_o.alu_op = ALU_SLT;
					3'b011: dec_o.alu_op = ALU_SLTU;
					3'b100: dec_o.alu_op = ALU_XOR;
					3'b110: dec_o.alu_op = ALU_OR;
					3'b111: dec_o.alu_op = ALU_AND;
					3'b001: begin
						dec_o.alu_op = ALU_SLL;
						dec_o.imm    = {27'b0, inst_i[24:20]};
					end
					default: begin
						dec_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
						dec_o.imm    = {27'b0, inst_i[24:20]};
					end
				endcase
			end
			OPC_OP: begin
				if (funct7 != FUNCT7_MULDIV) begin
					dec_o.rd           = inst_i[11:7];
					dec_o.use_zero_rs1 = 1'b0;
					dec_o.use_imm      = 1'b0;
					case (funct3)
						3'b000:  dec_o.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
						3'b001:  dec_o.alu_op = ALU_SLL;
						3'b010:  dec_o.alu_op = ALU_SLT;
						3'b011:  dec_o.alu_op = ALU_SLTU;
						3'b100:  dec_o.alu_op = ALU_XOR;
						3'b101:  dec_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
						3'b110:  dec_o.alu_op = ALU_OR;
						default: dec_o.alu_op = ALU_AND;
					endcase
				end else if (funct3 == 3'b000) begin
					// only mul from the M group, the rest stay no-ops
					dec_o.rd           = inst_i[11:7];
					dec_o.use_zero_rs1 = 1'b0;
					dec_o.use_imm      = 1'b0;
					dec_o.is_mul       = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile
	import core_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  reg_addr_t rs1_addr_i,
	input  reg_addr_t rs2_addr_i,
	output word_t     rs1_data_o,
	output word_t     rs2_data_o,
	input  logic      wr_en_i,
	input  reg_addr_t wr_addr_i,
	input  word_t     wr_data_i
);

	word_t regs_q [1:31];

	// x0 reads as zero
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en_i && (wr_addr_i != '0)) begin
			regs_q[wr_addr_i] <= wr_data_i;
		end
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu
	import core_pkg::*;
(
	input  alu_op_e op_i,
	input  word_t   a_i,
	input  word_t   b_i,
	output word_t   result_o
);

	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		case (op_i)
			ALU_ADD:  result_o = a_i + b_i;
			ALU_SUB:  result_o = a_i - b_i;
			ALU_SLL:  result_o = a_i << shamt;
			ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
			ALU_SLTU: result_o = {31'b0, a_i < b_i};
			ALU_XOR:  result_o = a_i ^ b_i;
			ALU_SRL:  result_o = a_i >> shamt;
			// arithmetic shift keeps the sign
			ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
			ALU_OR:   result_o = a_i | b_i;
			ALU_AND:  result_o = a_i & b_i;
			default:  result_o = '0;
		endcase
	end

endmodule

// File: verilog/mul_unit.sv
`timescale 1ns/1ps

module mul_unit
	import core_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  start_i,
	input  word_t a_i,
	input  word_t b_i,
	output logic  done_o,
	output word_t result_o
);

	mul_state_e                     state_q;
	logic [$clog2(MUL_STEPS)-1:0]   step_q;
	word_t                          acc_q;
	word_t                          mcand_q;
	word_t                          mplier_q;

	assign result_o = acc_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= MUL_IDLE;
			step_q  <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				MUL_IDLE: begin
					if (start_i) begin
						state_q <= MUL_BUSY;
						step_q  <= '0;
					end
				end
				default: begin
					step_q <= step_q + 1'b1;
					if (step_q == ($clog2(MUL_STEPS))'(MUL_STEPS - 1)) begin
						state_q <= MUL_IDLE;
						done_o  <= 1'b1;
					end
				end
			endcase
		end
	end

	// shift-add, one multiplier bit per cycle, low word only
	always_ff @(posedge clock) begin
		if (start_i) begin
			acc_q    <= '0;
			mcand_q  <= a_i;
			mplier_q <= b_i;
		end else if (state_q == MUL_BUSY) begin
			if (mplier_q[0]) begin
				acc_q <= acc_q + mcand_q;
			end
			mcand_q  <= mcand_q << 1;
			mplier_q <= mplier_q >> 1;
		end
	end

	start_idle_a: assert property (@(posedge clock) disable iff (reset)
		start_i |-> state_q == MUL_IDLE)
		else $error("mul_unit: start while busy");

	// execute relies on this latency to release issue
	done_latency_a: assert property (@(posedge clock) disable iff (reset)
		start_i |-> ##(MUL_STEPS + 1) done_o)
		else $error("mul_unit: done pulse missing");

endmodule

// File: verilog/exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe
	import core_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      head_valid_i,
	input  decoded_t  dec_i,
	output logic      issue_ready_o,
	output reg_addr_t rs1_addr_o,
	output reg_addr_t rs2_addr_o,
	input  word_t     rs1_data_i,
	input  word_t     rs2_data_i,
	output logic      wb_en_o,
	output reg_addr_t wb_addr_o,
	output word_t     wb_data_o,
	output logic      retire_valid_o,
	output retire_t   retire_o
);

	logic     issue;
	logic     ex_busy;
	logic     ex_adv;
	word_t    fwd_a;
	word_t    fwd_b;
	logic     ex_valid_q;
	decoded_t ex_dec_q;
	word_t    ex_a_q;
	word_t    ex_b_q;
	word_t    alu_a;
	word_t    alu_b;
	word_t    alu_result;
	word_t    ex_result;
	logic     mul_start;
	logic     mul_done;
	word_t    mul_result;
	logic     wb_valid_q;
	retire_t  wb_q;

	assign rs1_addr_o = dec_i.rs1;
	assign rs2_addr_o = dec_i.rs2;

	// a mul holds execute until its done pulse
	assign ex_busy       = ex_valid_q & ex_dec_q.is_mul & ~mul_done;
	assign issue_ready_o = ~ex_busy;
	assign issue         = head_valid_i & issue_ready_o;
	assign ex_adv        = ex_valid_q & ~ex_busy;
	assign ex_result     = ex_dec_q.is_mul ? mul_result : alu_result;

	// newest producer wins: execute, then write-back, then regfile
	function automatic word_t forward(input reg_addr_t rs, input word_t rf_data);
		word_t val;
		val = rf_data;
		if ((rs != '0) && ex_valid_q && (rs == ex_dec_q.rd)) begin
			val = ex_result;
		end else if ((rs != '0) && wb_valid_q && (rs == wb_q.rd)) begin
			val = wb_q.result;
		end
		return val;
	endfunction

	always_comb begin
		fwd_a = forward(dec_i.rs1, rs1_data_i);
		fwd_b = forward(dec_i.rs2, rs2_data_i);
	end

	assign mul_start = issue & dec_i.is_mul;

	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid_q <= 1'b0;
		end else if (issue) begin
			ex_valid_q <= 1'b1;
		end else if (ex_adv) begin
			ex_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			ex_dec_q <= dec_i;
			ex_a_q   <= fwd_a;
			ex_b_q   <= fwd_b;
		end
	end

	assign alu_a = ex_dec_q.use_zero_rs1 ? '0 : ex_a_q;
	assign alu_b = ex_dec_q.use_imm ? ex_dec_q.imm : ex_b_q;

	alu u_alu (
		.op_i     (ex_dec_q.alu_op),
		.a_i      (alu_a),
		.b_i      (alu_b),
		.result_o (alu_result)
	);

	mul_unit u_mul (
		.clock    (clock),
		.reset    (reset),
		.start_i  (mul_start),
		.a_i      (fwd_a),
		.b_i      (fwd_b),
		.done_o   (mul_done),
		.result_o (mul_result)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= ex_adv;
		end
	end

	always_ff @(posedge clock) begin
		if (ex_adv) begin
			wb_q.rd     <= ex_dec_q.rd;
			wb_q.result <= ex_result;
		end
	end

	// write-back and retire in the same cycle
	assign wb_en_o        = wb_valid_q;
	assign wb_addr_o      = wb_q.rd;
	assign wb_data_o      = wb_q.result;
	assign retire_valid_o = wb_valid_q;
	assign retire_o       = wb_q;

endmodule

// File: verilog/core_top.sv
`timescale 1ns/1ps

module core_top
	import core_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    inst_valid_i,
	input  inst_t   inst_i,
	output logic    credit_o,
	output logic    retire_valid_o,
	output retire_t retire_o
);

	logic      head_valid;
	inst_t     head_inst;
	logic      issue_ready;
	decoded_t  dec;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rs1_data;
	word_t     rs2_data;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;

	inst_queue u_queue (
		.clock        (clock),
		.reset        (reset),
		.push_i       (inst_valid_i),
		.push_inst_i  (inst_i),
		.head_valid_o (head_valid),
		.head_inst_o  (head_inst),
		.pop_i        (issue_ready),
		.credit_o     (credit_o)
	);

	decoder u_dec (
		.inst_i (head_inst),
		.dec_o  (dec)
	);

	regfile u_rf (
		.clock      (clock),
		.reset      (reset),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wr_en_i    (wb_en),
		.wr_addr_i  (wb_addr),
		.wr_data_i  (wb_data)
	);

	exec_pipe u_exec (
		.clock          (clock),
		.reset          (reset),
		.head_valid_i   (head_valid),
		.dec_i          (dec),
		.issue_ready_o  (issue_ready),
		.rs1_addr_o     (rs1_addr),
		.rs2_addr_o     (rs2_addr),
		.rs1_data_i     (rs1_data),
		.rs2_data_i     (rs2_data),
		.wb_en_o        (wb_en),
		.wb_addr_o      (wb_addr),
		.wb_data_o      (wb_data),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o)
	);

endmodule

// File: sim/tb_cases.svh
// columns: instruction word, expected rd, expected result
// all registers start at zero
localparam int NUM_CASES = 33;

typedef struct packed {
	inst_t     inst;
	reg_addr_t rd;
	word_t     result;
} case_t;

case_t cases [NUM_CASES] = '{
	// addi x1,-5; lui x2; xori x3,x2; ori x4,x0; andi x5,x3; slti x6,x1,-1; sltiu x7,x1,5
	'{32'hFFB00093, 5'd1,  32'hFFFFFFFB},
	'{32'h12345137, 5'd2,  32'h12345000},
	'{32'h0FF14193, 5'd3,  32'h123450FF},
	'{32'h55506213, 5'd4,  32'h00000555},
	'{32'h7F01F293, 5'd5,  32'h000000F0},
	'{32'hFFF0A313, 5'd6,  32'h00000001},
	'{32'h0050B393, 5'd7,  32'h00000000},
	// dependent chain x8..x14, with add x0 in the middle and a read of x0 after it
	'{32'h00120433, 5'd8,  32'h00000550},
	'{32'h008404B3, 5'd9,  32'h00000AA0},
	'{32'h40848533, 5'd10, 32'h00000550},
	'{32'h00848033, 5'd0,  32'h00000FF0},
	'{32'h00A005B3, 5'd11, 32'h00000550},
	'{32'h0095E633, 5'd12, 32'h00000FF0},
	'{32'h00B676B3, 5'd13, 32'h00000550},
	'{32'h00C6C733, 5'd14, 32'h00000AA0},
	// x16 = 4, then sll/srl/sra of x1, srai, slli, slt vs sltu, sub that wraps
	'{32'h00400813, 5'd16, 32'h00000004},
	'{32'h010097B3, 5'd15, 32'hFFFFFFB0},
	'{32'h0100D8B3, 5'd17, 32'h0FFFFFFF},
	'{32'h4100D933, 5'd18, 32'hFFFFFFFF},
	'{32'h4027D993, 5'd19, 32'hFFFFFFEC},
	'{32'h00321A13, 5'd20, 32'h00002AA8},
	'{32'h0040AAB3, 5'd21, 32'h00000001},
	'{32'h0040BB33, 5'd22, 32'h00000000},
	'{32'h40400BB3, 5'd23, 32'hFFFFFAAB},
	// mul x24 = x4*x16, addi on it, mul with a negative operand, dependent mul
	'{32'h03020C33, 5'd24, 32'h00001554},
	'{32'h001C0C93, 5'd25, 32'h00001555},
	'{32'h03708D33, 5'd26, 32'h00001AA9},
	'{32'h021D0DB3, 5'd27, 32'hFFFF7AB3},
	'{32'h01BC8E33, 5'd28, 32'hFFFF9008},
	'{32'hFFFFFEB7, 5'd29, 32'hFFFFF000},
	'{32'h03DE8F33, 5'd30, 32'h01000000},
	// sw x1,0(x2) is not supported and retires as a no-op
	'{32'h00112023, 5'd0,  32'h00000000},
	'{32'hFFFF0F93, 5'd31, 32'h00FFFFFF}
};

// File: sim/core_tb.sv
`timescale 1ns/1ps

module core_tb
	import core_pkg::*;
();

	`include "tb_cases.svh"

	localparam int RESET_CYCLES   = 10;
	localparam int TIMEOUT_CYCLES = NUM_CASES * (MUL_STEPS + 6) + RESET_CYCLES;

	logic    clock;
	logic    reset;
	logic    inst_valid;
	inst_t   inst_word;
	logic    credit;
	logic    retire_valid;
	retire_t retire;

	int credits;
	int retired;
	int cycles;
	int value_errors;
	int other_errors;

	core_top dut (
		.clock          (clock),
		.reset          (reset),
		.inst_valid_i   (inst_valid),
		.inst_i         (inst_word),
		.credit_o       (credit),
		.retire_valid_o (retire_valid),
		.retire_o       (retire)
	);

	always #4 clock = ~clock;

	task automatic idle_cycle();
		inst_valid = 1'b0;
		@(posedge clock);
		#1;
	endtask

	task automatic send_inst(input inst_t word);
		inst_valid = 1'b1;
		inst_word  = word;
		credits--;
		@(posedge clock);
		#1;
	endtask

	task automatic check_retire(input int idx);
		assert (retire.rd == cases[idx].rd)
		else begin
			value_errors++;
			$display("error: row %0d retire_o.rd = 0x%h, expected 0x%h",
				idx, retire.rd, cases[idx].rd);
		end
		assert (retire.result == cases[idx].result)
		else begin
			value_errors++;
			$display("error: row %0d retire_o.result = 0x%h, expected 0x%h",
				idx, retire.result, cases[idx].result);
		end
	endtask

	// a pulse seen at this edge is spendable from the next cycle on
	always @(posedge clock) begin
		if (!reset && credit) begin
			credits = credits + 1;
			assert (credits <= INST_QUEUE_DEPTH)
			else begin
				other_errors++;
				$display("more credits came back than the queue holds");
			end
		end
	end

	// retire outputs are settled by the falling edge
	always @(negedge clock) begin
		if (!reset && retire_valid) begin
			assert (retired < NUM_CASES)
			else begin
				other_errors++;
				$display("a retire came after the last table row");
			end
			if (retired < NUM_CASES) begin
				check_retire(retired);
			end
			retired++;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles, retires stopped at %0d of %0d",
			cycles, retired, NUM_CASES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int gap;
		clock        = 1'b0;
		reset        = 1'b1;
		inst_valid   = 1'b0;
		inst_word    = '0;
		credits      = INST_QUEUE_DEPTH;
		retired      = 0;
		value_errors = 0;
		other_errors = 0;
		void'($urandom(75));
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;

		for (int i = 0; i < NUM_CASES; i++) begin
			gap = $urandom % 3;
			repeat (gap) idle_cycle();
			// wait for issue to hand back a slot
			while (credits == 0) begin
				idle_cycle();
			end
			send_inst(cases[i].inst);
		end
		inst_valid = 1'b0;

		wait (retired == NUM_CASES);
		repeat (3) @(posedge clock);
		#1;
		assert (credits == INST_QUEUE_DEPTH)
		else begin
			other_errors++;
			$display("driver ends with %0d credits instead of %0d",
				credits, INST_QUEUE_DEPTH);
		end

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+sim
verilog/core_pkg.sv
verilog/inst_queue.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/mul_unit.sv
verilog/exec_pipe.sv
verilog/core_top.sv
sim/core_tb.sv
